/* src/cpu_pkg.sv */
// Package with bus widths, opcodes, the instruction word union and ALU operations
`default_nettype none

package cpu_pkg;

    localparam int word_w    = 16;
    localparam int reg_sel_w = 3;

    // Opcodes 9 to 14 are unassigned and run as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDI  = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_XOR  = 4'd5,
        OP_LD   = 4'd6,
        OP_ST   = 4'd7,
        OP_JNZ  = 4'd8,
        OP_HALT = 4'd15
    } opcode_t;

    // Two-register form: ADD, SUB, AND, XOR, LD, ST
    typedef struct packed {
        opcode_t              op;
        logic [reg_sel_w-1:0] rd;
        logic [reg_sel_w-1:0] rs;
        logic [5:0]           unused;
    } instr_reg_t;

    // Immediate form: LDI, JNZ
    typedef struct packed {
        opcode_t              op;
        logic [reg_sel_w-1:0] rd;
        logic                 unused;
        logic [7:0]           imm8;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_PASS_A,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR
    } alu_op_t;

endpackage

`default_nettype wire

/* src/mem_req_if.sv */
// Interface for a single memory access between the controller and the bus controller
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

    logic                       req;
    logic                       wr;
    logic [cpu_pkg::word_w-1:0] addr;
    logic [cpu_pkg::word_w-1:0] wdata;
    // Valid while rdy is high
    logic [cpu_pkg::word_w-1:0] rdata;
    logic                       rdy;

    modport master (
        output req, wr, addr, wdata,
        input  rdata, rdy
    );

    modport slave (
        input  req, wr, addr, wdata,
        output rdata, rdy
    );

endinterface

`default_nettype wire

/* src/cpu_alu.sv */
// Combinational ALU with add, subtract, and, xor, pass-through and a zero flag
`timescale 1ns/1ps
`default_nettype none

module cpu_alu(
    input  wire  [cpu_pkg::word_w-1:0] a,
    input  wire  [cpu_pkg::word_w-1:0] b,
    input  wire  cpu_pkg::alu_op_t     op,

    output logic [cpu_pkg::word_w-1:0] result,
    output logic                       zero
);

always_comb begin
    case (op)
        // Carries out of bit 15 are dropped
        cpu_pkg::ALU_ADD: result = a + b;
        cpu_pkg::ALU_SUB: result = a - b;
        cpu_pkg::ALU_AND: result = a & b;
        cpu_pkg::ALU_XOR: result = a ^ b;
        default:          result = a;
    endcase
end

assign zero = result == '0;

endmodule

`default_nettype wire

/* src/cpu_regs.sv */
// Eight-entry register bank with two read ports, one write port and a dump port
`timescale 1ns/1ps
`default_nettype none

module cpu_regs(
    input  wire                            clk,
    input  wire                            cen,
    input  wire                            arst_n,

    input  wire [cpu_pkg::reg_sel_w-1:0]   ra_sel,
    input  wire [cpu_pkg::reg_sel_w-1:0]   rb_sel,
    input  wire [cpu_pkg::reg_sel_w-1:0]   wr_sel,
    input  wire [cpu_pkg::reg_sel_w-1:0]   dmp_addr,
    input  wire                            wr_en,
    input  wire [cpu_pkg::word_w-1:0]      wr_data,

    output logic [cpu_pkg::word_w-1:0]     ra_data,
    output logic [cpu_pkg::word_w-1:0]     rb_data,
    output logic [cpu_pkg::word_w-1:0]     dmp_dout
);

localparam int NREGS = 1 << cpu_pkg::reg_sel_w;

logic [cpu_pkg::word_w-1:0] regs [NREGS];

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < NREGS; i++)
            regs[i] <= '0;
    end else if (cen && wr_en) begin
        regs[wr_sel] <= wr_data;
    end
end

// Reads see the stored value only, a write lands on the next cycle
assign ra_data  = regs[ra_sel];
assign rb_data  = regs[rb_sel];
assign dmp_dout = regs[dmp_addr];

endmodule

`default_nettype wire

/* src/cpu_pc.sv */
// Program counter with reset value, increment and jump load
`timescale 1ns/1ps
`default_nettype none

module cpu_pc #(
    parameter logic [15:0] PC_RSTVAL = 16'h0000
)(
    input  wire                        clk,
    input  wire                        cen,
    input  wire                        arst_n,

    input  wire                        inc,
    input  wire                        load,
    input  wire  [cpu_pkg::word_w-1:0] target,

    output logic [cpu_pkg::word_w-1:0] pc
);

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        pc <= PC_RSTVAL;
    end else if (cen) begin
        // Jumps win over the increment
        if (load)
            pc <= target;
        else if (inc)
            pc <= pc + 1'b1;
    end
end

endmodule

`default_nettype wire

/* src/cpu_memctl.sv */
// External bus controller: drives address, data and write strobe and waits out busy
`timescale 1ns/1ps
`default_nettype none

module cpu_memctl(
    input  wire                        clk,
    input  wire                        cen,
    input  wire                        arst_n,

    input  wire  [cpu_pkg::word_w-1:0] din,
    input  wire                        busy,

    mem_req_if.slave                   req,

    output logic [cpu_pkg::word_w-1:0] addr,
    output logic [cpu_pkg::word_w-1:0] dout,
    output logic                       we
);

logic active;
logic done;

// Transfer ends on the first enabled cycle without busy
assign done = cen && active && !busy;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        active  <= 1'b0;
        we      <= 1'b0;
        addr    <= '0;
        dout    <= '0;
        req.rdy <= 1'b0;
    end else if (cen) begin
        // rdy lasts until the next enabled cycle so the FSM cannot miss it
        req.rdy <= 1'b0;
        if (!active) begin
            if (req.req) begin
                active <= 1'b1;
                addr   <= req.addr;
                dout   <= req.wdata;
                we     <= req.wr;
            end
        end else if (!busy) begin
            active  <= 1'b0;
            we      <= 1'b0;
            req.rdy <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (done)
        req.rdata <= din;
end

endmodule

`default_nettype wire

/* src/cpu_ctrl.sv */
// Instruction controller FSM: fetch, decode, execute, memory access and writeback
`timescale 1ns/1ps
`default_nettype none

module cpu_ctrl(
    input  wire                              clk,
    input  wire                              cen,
    input  wire                              arst_n,

    input  wire                              alu_zero,
    input  wire        [cpu_pkg::word_w-1:0] alu_result,
    input  wire        [cpu_pkg::word_w-1:0] ra_data,
    input  wire        [cpu_pkg::word_w-1:0] rb_data,
    input  wire        [cpu_pkg::word_w-1:0] pc,

    mem_req_if.master                        mem,

    output logic     [cpu_pkg::reg_sel_w-1:0] ra_sel,
    output logic     [cpu_pkg::reg_sel_w-1:0] rb_sel,
    output logic     [cpu_pkg::reg_sel_w-1:0] wr_sel,
    output logic                             wr_en,
    output logic       [cpu_pkg::word_w-1:0] wr_data,
    output cpu_pkg::alu_op_t                 alu_op,
    output logic       [cpu_pkg::word_w-1:0] alu_a,
    output logic                             pc_inc,
    output logic                             pc_load,
    output logic       [cpu_pkg::word_w-1:0] pc_target,
    output logic                             halted
);

localparam logic [2:0] S_FETCH      = 3'd0,
                       S_WAIT_FETCH = 3'd1,
                       S_EXEC       = 3'd2,
                       S_WAIT_MEM   = 3'd3,
                       S_HALT       = 3'd4;

logic [2:0]               state;
cpu_pkg::instr_t          ir;
logic                     is_mem;
logic [cpu_pkg::word_w-1:0] imm_ext;

assign is_mem  = ir.r.op == cpu_pkg::OP_LD || ir.r.op == cpu_pkg::OP_ST;
assign imm_ext = { {(cpu_pkg::word_w-8){1'b0}}, ir.i.imm8 };
assign halted  = state == S_HALT;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state <= S_FETCH;
    end else if (cen) begin
        case (state)
            S_FETCH:      state <= S_WAIT_FETCH;
            S_WAIT_FETCH: if (mem.rdy) state <= S_EXEC;
            S_EXEC: begin
                if (ir.r.op == cpu_pkg::OP_HALT)
                    state <= S_HALT;
                else if (is_mem)
                    state <= S_WAIT_MEM;
                else
                    state <= S_FETCH;
            end
            S_WAIT_MEM:   if (mem.rdy) state <= S_FETCH;
            S_HALT:       state <= S_HALT;
            default:      state <= S_FETCH;
        endcase
    end
end

// Instruction register
always_ff @(posedge clk) begin
    if (cen && state == S_WAIT_FETCH && mem.rdy)
        ir <= mem.rdata;
end

always_comb begin
    ra_sel    = ir.r.rd;
    rb_sel    = ir.r.rs;
    wr_sel    = ir.r.rd;
    wr_en     = 1'b0;
    wr_data   = alu_result;
    alu_op    = cpu_pkg::ALU_PASS_A;
    alu_a     = ra_data;
    pc_inc    = 1'b0;
    pc_load   = 1'b0;
    pc_target = imm_ext;
    // Fetch address comes straight from the PC
    mem.req   = 1'b0;
    mem.wr    = 1'b0;
    mem.addr  = pc;
    mem.wdata = ra_data;
    case (state)
        S_FETCH: mem.req = 1'b1;
        S_EXEC: begin
            case (ir.r.op)
                cpu_pkg::OP_LDI: begin
                    alu_a  = imm_ext;
                    wr_en  = 1'b1;
                    pc_inc = 1'b1;
                end
                cpu_pkg::OP_ADD: begin
                    alu_op = cpu_pkg::ALU_ADD;
                    wr_en  = 1'b1;
                    pc_inc = 1'b1;
                end
                cpu_pkg::OP_SUB: begin
                    alu_op = cpu_pkg::ALU_SUB;
                    wr_en  = 1'b1;
                    pc_inc = 1'b1;
                end
                cpu_pkg::OP_AND: begin
                    alu_op = cpu_pkg::ALU_AND;
                    wr_en  = 1'b1;
                    pc_inc = 1'b1;
                end
                cpu_pkg::OP_XOR: begin
                    alu_op = cpu_pkg::ALU_XOR;
                    wr_en  = 1'b1;
                    pc_inc = 1'b1;
                end
                // Address register is rs, data register is rd
                cpu_pkg::OP_LD: begin
                    mem.req  = 1'b1;
                    mem.addr = rb_data;
                end
                cpu_pkg::OP_ST: begin
                    mem.req  = 1'b1;
                    mem.wr   = 1'b1;
                    mem.addr = rb_data;
                end
                cpu_pkg::OP_JNZ: begin
                    // rd passes through the ALU to test it for zero
                    pc_load = !alu_zero;
                    pc_inc  = alu_zero;
                end
                cpu_pkg::OP_HALT: ;
                default: pc_inc = 1'b1;
            endcase
        end
        S_WAIT_MEM: begin
            if (mem.rdy) begin
                pc_inc  = 1'b1;
                wr_en   = ir.r.op == cpu_pkg::OP_LD;
                wr_data = mem.rdata;
            end
        end
        default: ;
    endcase
end

endmodule

`default_nettype wire

/* src/cpu_top.sv */
// Core top level: controller, register bank, ALU, PC and bus controller
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter logic [15:0] PC_RSTVAL = 16'h0000
)(
    input  wire         clk,
    input  wire         cen,
    input  wire         arst_n,

    output logic [15:0] addr,
    input  wire  [15:0] din,
    output logic [15:0] dout,
    output logic        we,
    input  wire         busy,
    output logic        halted,

    // Register dump
    input  wire  [ 2:0] dmp_addr,
    output logic [15:0] dmp_dout
);

logic [cpu_pkg::reg_sel_w-1:0] ra_sel, rb_sel, wr_sel;
logic [cpu_pkg::word_w-1:0]    ra_data, rb_data, wr_data;
logic                          wr_en;

logic [cpu_pkg::word_w-1:0]    alu_a, alu_result;
cpu_pkg::alu_op_t              alu_op;
logic                          alu_zero;

logic [cpu_pkg::word_w-1:0]    pc, pc_target;
logic                          pc_inc, pc_load;

mem_req_if u_mem_if();

cpu_ctrl u_ctrl(
    .clk        ( clk           ),
    .cen        ( cen           ),
    .arst_n     ( arst_n        ),
    .alu_zero   ( alu_zero      ),
    .alu_result ( alu_result    ),
    .ra_data    ( ra_data       ),
    .rb_data    ( rb_data       ),
    .pc         ( pc            ),
    .mem        ( u_mem_if      ),
    .ra_sel     ( ra_sel        ),
    .rb_sel     ( rb_sel        ),
    .wr_sel     ( wr_sel        ),
    .wr_en      ( wr_en         ),
    .wr_data    ( wr_data       ),
    .alu_op     ( alu_op        ),
    .alu_a      ( alu_a         ),
    .pc_inc     ( pc_inc        ),
    .pc_load    ( pc_load       ),
    .pc_target  ( pc_target     ),
    .halted     ( halted        )
);

cpu_regs u_regs(
    .clk        ( clk           ),
    .cen        ( cen           ),
    .arst_n     ( arst_n        ),
    .ra_sel     ( ra_sel        ),
    .rb_sel     ( rb_sel        ),
    .wr_sel     ( wr_sel        ),
    .dmp_addr   ( dmp_addr      ),
    .wr_en      ( wr_en         ),
    .wr_data    ( wr_data       ),
    .ra_data    ( ra_data       ),
    .rb_data    ( rb_data       ),
    .dmp_dout   ( dmp_dout      )
);

// Operand b always comes from the rs read port
cpu_alu u_alu(
    .a          ( alu_a         ),
    .b          ( rb_data       ),
    .op         ( alu_op        ),
    .result     ( alu_result    ),
    .zero       ( alu_zero      )
);

cpu_pc #(.PC_RSTVAL(PC_RSTVAL)) u_pc(
    .clk        ( clk           ),
    .cen        ( cen           ),
    .arst_n     ( arst_n        ),
    .inc        ( pc_inc        ),
    .load       ( pc_load       ),
    .target     ( pc_target     ),
    .pc         ( pc            )
);

cpu_memctl u_memctl(
    .clk        ( clk           ),
    .cen        ( cen           ),
    .arst_n     ( arst_n        ),
    .din        ( din           ),
    .busy       ( busy          ),
    .req        ( u_mem_if      ),
    .addr       ( addr          ),
    .dout       ( dout          ),
    .we         ( we            )
);

endmodule

`default_nettype wire

/* tests/tb_mem_model.sv */
// Word-addressed bus memory model with the test program and its data words
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model(
    input  wire         clk,
    input  wire         cen,
    input  wire         busy,
    input  wire  [15:0] addr,
    input  wire  [15:0] wdata,
    input  wire         we,
    output logic [15:0] rdata
);

logic [15:0] mem [65536];

function automatic logic [15:0] rr_word(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs);
    return {op, rd, rs, 6'b000000};
endfunction

function automatic logic [15:0] imm_word(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [7:0] imm);
    return {op, rd, 1'b0, imm};
endfunction

initial begin
    int a;
    // Background pattern built from every address bit
    for (a = 0; a < 65536; a++)
        mem[a] = {a[7:0], a[15:8]} ^ 16'hc3a5;

    // Load two data words and combine them
    mem[16'h0010] = imm_word(cpu_pkg::OP_LDI, 3'd1, 8'h80);
    mem[16'h0011] = rr_word(cpu_pkg::OP_LD,   3'd2, 3'd1);
    mem[16'h0012] = imm_word(cpu_pkg::OP_LDI, 3'd3, 8'h81);
    mem[16'h0013] = rr_word(cpu_pkg::OP_LD,   3'd4, 3'd3);
    mem[16'h0014] = rr_word(cpu_pkg::OP_ADD,  3'd2, 3'd4);
    mem[16'h0015] = imm_word(cpu_pkg::OP_LDI, 3'd5, 8'ha0);
    mem[16'h0016] = rr_word(cpu_pkg::OP_ST,   3'd2, 3'd5);
    mem[16'h0017] = imm_word(cpu_pkg::OP_LDI, 3'd6, 8'h5c);
    mem[16'h0018] = rr_word(cpu_pkg::OP_SUB,  3'd6, 3'd4);
    mem[16'h0019] = imm_word(cpu_pkg::OP_LDI, 3'd5, 8'ha1);
    mem[16'h001a] = rr_word(cpu_pkg::OP_ST,   3'd6, 3'd5);
    mem[16'h001b] = imm_word(cpu_pkg::OP_LDI, 3'd7, 8'h3c);
    mem[16'h001c] = rr_word(cpu_pkg::OP_AND,  3'd7, 3'd2);
    mem[16'h001d] = imm_word(cpu_pkg::OP_LDI, 3'd5, 8'ha2);
    mem[16'h001e] = rr_word(cpu_pkg::OP_ST,   3'd7, 3'd5);
    mem[16'h001f] = rr_word(cpu_pkg::OP_XOR,  3'd7, 3'd4);
    mem[16'h0020] = imm_word(cpu_pkg::OP_LDI, 3'd5, 8'ha3);
    mem[16'h0021] = rr_word(cpu_pkg::OP_ST,   3'd7, 3'd5);
    // Countdown loop, one store per counter value
    mem[16'h0022] = imm_word(cpu_pkg::OP_LDI, 3'd0, 8'h04);
    mem[16'h0023] = imm_word(cpu_pkg::OP_LDI, 3'd1, 8'h01);
    mem[16'h0024] = imm_word(cpu_pkg::OP_LDI, 3'd5, 8'hb0);
    mem[16'h0025] = rr_word(cpu_pkg::OP_ST,   3'd0, 3'd5);
    mem[16'h0026] = rr_word(cpu_pkg::OP_ADD,  3'd5, 3'd1);
    mem[16'h0027] = rr_word(cpu_pkg::OP_SUB,  3'd0, 3'd1);
    mem[16'h0028] = imm_word(cpu_pkg::OP_JNZ, 3'd0, 8'h25);
    mem[16'h0029] = rr_word(cpu_pkg::OP_ST,   3'd0, 3'd5);
    mem[16'h002a] = 16'h0000;
    // Unassigned opcode runs as NOP
    mem[16'h002b] = 16'ha000;
    mem[16'h002c] = rr_word(cpu_pkg::OP_HALT, 3'd0, 3'd0);

    mem[16'h0080] = 16'h1234;
    mem[16'h0081] = 16'hf0f3;
end

// A write lands on the cycle that completes the transfer
always @(posedge clk) begin
    if (cen && we && !busy)
        mem[addr] <= wdata;
end

assign rdata = mem[addr];

endmodule

`default_nettype wire

/* tests/tb_cpu.sv */
// Testbench for the core: clock, reset, random stalls, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

logic        clk;
logic        cen;
logic        arst_n;
logic        busy;
logic [15:0] din;
logic [15:0] addr;
logic [15:0] dout;
logic        we;
logic        halted;
logic [2:0]  dmp_addr;
logic [15:0] dmp_dout;

logic [31:0] rnd;
int          errors;
int          nwrites;
bit          timed_out;

// Model state and predicted bus writes
logic [15:0] ref_mem [65536];
logic [15:0] ref_regs [8];
logic [15:0] exp_waddr [$];
logic [15:0] exp_wdata [$];

// Bus outputs of the previous cycle and whether they had to hold
bit          held;
logic [15:0] held_addr;
logic [15:0] held_dout;
logic        held_we;

cpu_top #(.PC_RSTVAL(16'h0010)) uut(
    .clk      ( clk      ),
    .cen      ( cen      ),
    .arst_n   ( arst_n   ),
    .addr     ( addr     ),
    .din      ( din      ),
    .dout     ( dout     ),
    .we       ( we       ),
    .busy     ( busy     ),
    .halted   ( halted   ),
    .dmp_addr ( dmp_addr ),
    .dmp_dout ( dmp_dout )
);

tb_mem_model u_mem(
    .clk   ( clk  ),
    .cen   ( cen  ),
    .busy  ( busy ),
    .addr  ( addr ),
    .wdata ( dout ),
    .we    ( we   ),
    .rdata ( din  )
);

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Instruction-level run of the program in memory, straight from the ISA
task automatic run_reference;
    logic [15:0] pc;
    logic [15:0] w;
    logic [3:0]  op;
    logic [2:0]  rd;
    logic [2:0]  rs;
    int          steps;
    int          a;
    bit          done;
    for (a = 0; a < 65536; a++)
        ref_mem[a] = u_mem.mem[a];
    for (a = 0; a < 8; a++)
        ref_regs[a] = 16'h0000;
    pc = 16'h0010;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
        w = ref_mem[pc];
        op = w[15:12];
        rd = w[11:9];
        rs = w[8:6];
        steps++;
        case (op)
            4'h1: ref_regs[rd] = {8'h00, w[7:0]};
            4'h2: ref_regs[rd] = ref_regs[rd] + ref_regs[rs];
            4'h3: ref_regs[rd] = ref_regs[rd] - ref_regs[rs];
            4'h4: ref_regs[rd] = ref_regs[rd] & ref_regs[rs];
            4'h5: ref_regs[rd] = ref_regs[rd] ^ ref_regs[rs];
            4'h6: ref_regs[rd] = ref_mem[ref_regs[rs]];
            4'h7: begin
                ref_mem[ref_regs[rs]] = ref_regs[rd];
                exp_waddr.push_back(ref_regs[rs]);
                exp_wdata.push_back(ref_regs[rd]);
            end
            4'hf: done = 1'b1;
            default: ;
        endcase
        if (op == 4'h8 && ref_regs[rd] != 16'h0000)
            pc = {8'h00, w[7:0]};
        else if (op != 4'hf)
            pc = pc + 16'd1;
    end
    if (!done) begin
        errors++;
        $display("Reference model ran %0d steps without reaching HALT", steps);
    end
endtask

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// Random stalls, about one cycle in eight without cen, one in three busy
always @(posedge clk) begin
    #1;
    rnd = xorshift32(rnd);
    cen = rnd[2:0] != 3'd0;
    busy = (rnd[15:8] % 8'd3) == 8'd0;
end

always @(posedge clk) begin
    if (arst_n && held) begin
        assert (addr == held_addr) else begin
            errors++;
            $display("[ERROR] %0t addr expected %h got %h", $time, held_addr, addr);
        end
        assert (dout == held_dout) else begin
            errors++;
            $display("[ERROR] %0t dout expected %h got %h", $time, held_dout, dout);
        end
        assert (we == held_we) else begin
            errors++;
            $display("[ERROR] %0t we expected %b got %b", $time, held_we, we);
        end
    end
    if (arst_n && cen && we && !busy) begin
        assert (exp_waddr.size() > 0) else begin
            errors++;
            $display("Bus write at %0t to %h with %h was not predicted", $time, addr, dout);
        end
        if (exp_waddr.size() > 0) begin
            assert (addr == exp_waddr[0]) else begin
                errors++;
                $display("[ERROR] %0t addr expected %h got %h", $time, exp_waddr[0], addr);
            end
            assert (dout == exp_wdata[0]) else begin
                errors++;
                $display("[ERROR] %0t dout expected %h got %h", $time, exp_wdata[0], dout);
            end
            void'(exp_waddr.pop_front());
            void'(exp_wdata.pop_front());
            nwrites++;
        end
    end
    // A pending write under busy, or a cycle without cen, freezes the bus
    held = arst_n && ((we && busy) || !cen);
    held_addr = addr;
    held_dout = dout;
    held_we = we;
end

halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else begin
        errors++;
        $display("halted went low at %0t after it had been set", $time);
    end

quiet_after_halt: assert property (@(posedge clk) disable iff (!arst_n) halted |-> !we)
    else begin
        errors++;
        $display("Write strobe was raised at %0t after the core halted", $time);
    end

initial begin
    int n;
    int i;
    arst_n = 1'b0;
    cen = 1'b1;
    busy = 1'b0;
    dmp_addr = 3'd0;
    rnd = 32'h4afda6f8;
    errors = 0;
    nwrites = 0;
    timed_out = 1'b0;
    held = 1'b0;

    repeat (10) @(posedge clk);
    assert (we == 1'b0) else begin
        errors++;
        $display("[ERROR] %0t we expected 0 got %b", $time, we);
    end
    assert (halted == 1'b0) else begin
        errors++;
        $display("[ERROR] %0t halted expected 0 got %b", $time, halted);
    end
    run_reference();
    #1 arst_n = 1'b1;

    // First address that leaves the reset value
    n = 0;
    while (addr == 16'h0000 && n < 100) begin
        @(posedge clk);
        n++;
    end
    if (addr == 16'h0000) begin
        errors++;
        timed_out = 1'b1;
        $display("Timeout: no bus address was presented after reset");
    end else begin
        assert (addr == 16'h0010) else begin
            errors++;
            $display("[ERROR] %0t addr expected 0010 got %h", $time, addr);
        end
    end

    if (!timed_out) begin
        n = 0;
        while (!halted && n < 20000) begin
            @(posedge clk);
            n++;
        end
        if (!halted) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: the core did not halt within %0d cycles", n);
        end
    end

    if (!timed_out) begin
        assert (exp_waddr.size() == 0) else begin
            errors++;
            $display("%0d predicted bus writes never happened", exp_waddr.size());
        end
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            #1 dmp_addr = i[2:0];
            @(posedge clk);
            assert (dmp_dout == ref_regs[i]) else begin
                errors++;
                $display("[ERROR] %0t dmp_dout r%0d expected %h got %h",
                         $time, i, ref_regs[i], dmp_dout);
            end
        end
    end

    $display("Run complete: %0d bus writes checked, %0d errors", nwrites, errors);
    if (errors == 0)
        $display("STATUS: PASS");
    else
        $display("STATUS: FAIL");
    $finish;
end

endmodule

`default_nettype wire

/* src.f */
src/cpu_pkg.sv
src/mem_req_if.sv
src/cpu_alu.sv
src/cpu_regs.sv
src/cpu_pc.sv
src/cpu_memctl.sv
src/cpu_ctrl.sv
src/cpu_top.sv
tests/tb_mem_model.sv
tests/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build the core and its testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0
